/* include/i2c_config_params.svh */
// codec configuration constants: device address, command count, word width, sync depth
`ifndef I2C_CONFIG_PARAMS_SVH
`define I2C_CONFIG_PARAMS_SVH

// one command word on the bus
// address byte, 7-bit register number, 9-bit data
`define I2C_CMD_WIDTH 24

// codec device address 0011010 with the write bit (0) appended
`define I2C_CODEC_ADDR 8'h34

// entries in the codec command table
// reset, power up, analog path, soft mute, sample rate, format, activate
`define I2C_NUM_CMDS 7

// flip-flops between clock_8_1k and the edge detector
// at least two, since the chain shifts in from the low end
`define I2C_SYNC_STAGES 2

`endif

/* rtl/i2c_config_pkg.sv */
// codec config types: command word struct, bus state enum, command table and index types
`default_nettype none

`include "i2c_config_params.svh"

package i2c_config_pkg;

    // one codec register write, msb goes out first
    typedef struct packed {
        logic [7:0] addr;
        logic [6:0] reg_num;
        logic [8:0] data;
    } i2c_cmd_t;

    // index into the command table
    typedef logic [2:0] item_idx_t;

    // full set of codec writes, entry 0 is sent first
    typedef i2c_cmd_t cmd_table_t [`I2C_NUM_CMDS];

    // bus phases of the bit engine, each phase lasts one step
    typedef enum logic [3:0] {
        st_idle,
        st_start1,
        st_start2,
        st_start3,
        st_data1,
        st_data2,
        st_data3,
        st_ack1,
        st_ack2,
        st_stop1,
        st_stop1_err,
        st_stop2,
        st_stop3
    } i2c_state_e;

endpackage

`default_nettype wire

/* rtl/i2c_cmd_if.sv */
// command handshake interface between command sequencer and bit engine, with modports
`timescale 1ns/1ns
`default_nettype none

interface i2c_cmd_if import i2c_config_pkg::*; ();

    // word to send, held stable until cmd_done
    i2c_cmd_t cmd;
    // low means nothing left to send
    logic     cmd_valid;
    // one-cycle pulse at the end of the stop condition
    logic     cmd_done;
    // qualifies cmd_done: all three slots acked
    logic     cmd_acked;

    modport seq (
        output cmd, cmd_valid,
        input  cmd_done, cmd_acked
    );

    modport eng (
        input  cmd, cmd_valid,
        output cmd_done, cmd_acked
    );

endinterface

`default_nettype wire

/* rtl/i2c_tick_gen.sv */
// step tick generator: clock_8_1k synchronizer, rising-edge detector, clock_valid gate
`timescale 1ns/1ns
`default_nettype none

`include "i2c_config_params.svh"

module i2c_tick_gen (
    input  logic osc_50,
    input  logic reset_50m,
    input  logic clock_8_1k,
    input  logic clock_valid,
    output logic step
);

    // synchronizer chain, top bit is the safe copy
    logic [`I2C_SYNC_STAGES-1:0] sync_q;
    // previous synchronized value for edge detection
    logic sync_last_q;
    logic clk_sync;

    assign clk_sync = sync_q[`I2C_SYNC_STAGES-1];

    always_ff @(posedge osc_50) begin
        if (reset_50m) begin
            sync_q      <= '0;
            sync_last_q <= 1'b0;
            step        <= 1'b0;
        end else begin
            sync_q      <= {sync_q[`I2C_SYNC_STAGES-2:0], clock_8_1k};
            sync_last_q <= clk_sync;
            // registered, so step lags the slow edge by stages + 1
            step        <= clock_valid && clk_sync && !sync_last_q;
        end
    end

    // slow clock is far below osc_50, a tick can never repeat back to back
    a_step_single : assert property (@(posedge osc_50) disable iff (reset_50m)
        step |=> !step);

endmodule

`default_nettype wire

/* rtl/i2c_command_seq.sv */
// codec command sequencer: constant command table, item counter, sticky audio done flag
`timescale 1ns/1ns
`default_nettype none

`include "i2c_config_params.svh"

module i2c_command_seq import i2c_config_pkg::*; (
    input  logic   osc_50,
    input  logic   reset_50m,
    i2c_cmd_if.seq cmd_port,
    output logic   i2c_audio_done
);

    // codec register writes in send order
    // fields: address byte, register number, data
    localparam cmd_table_t codec_table = '{
        // reset register, any write resets the codec
        '{`I2C_CODEC_ADDR, 7'h0f, 9'h000},
        // power down control, everything on
        '{`I2C_CODEC_ADDR, 7'h06, 9'h000},
        // analog path: DAC to output, mic to ADC
        '{`I2C_CODEC_ADDR, 7'h04, 9'h014},
        // digital path, soft mute off
        '{`I2C_CODEC_ADDR, 7'h05, 9'h000},
        // sampling control
        '{`I2C_CODEC_ADDR, 7'h08, 9'h00c},
        // digital audio interface format
        '{`I2C_CODEC_ADDR, 7'h07, 9'h01b},
        // active control, start the interface
        '{`I2C_CODEC_ADDR, 7'h09, 9'h001}
    };

    localparam item_idx_t last_item = item_idx_t'(`I2C_NUM_CMDS - 1);

    // current table entry
    item_idx_t item_q;
    // set once the last entry is acked
    logic      done_q;

    assign cmd_port.cmd       = codec_table[item_q];
    assign cmd_port.cmd_valid = !done_q;
    assign i2c_audio_done     = done_q;

    always_ff @(posedge osc_50) begin
        if (reset_50m) begin
            item_q <= '0;
            done_q <= 1'b0;
        end else if (cmd_port.cmd_done && cmd_port.cmd_acked && !done_q) begin
            // nack leaves the item alone, so the same word goes out again
            if (item_q == last_item) begin
                done_q <= 1'b1;
            end else begin
                item_q <= item_q + item_idx_t'(1);
            end
        end
    end

    // counter parks on the last entry, never runs past the table
    a_item_range : assert property (@(posedge osc_50) disable iff (reset_50m)
        item_q <= last_item);

endmodule

`default_nettype wire

/* rtl/i2c_bit_engine.sv */
// I2C write engine: bus FSM, shift register, ack check, open-drain sclk and sdat pads
`timescale 1ns/1ns
`default_nettype none

`include "i2c_config_params.svh"

module i2c_bit_engine import i2c_config_pkg::*; (
    input  logic   osc_50,
    input  logic   reset_50m,
    input  logic   step,
    i2c_cmd_if.eng cmd_port,
    inout  wire    i2c_sdat,
    output wire    i2c_sclk
);

    localparam int cnt_w = $clog2(`I2C_CMD_WIDTH + 1);

    i2c_state_e state_q;
    // registered line levels, 1 means released
    logic sclk_q;
    logic sdat_q;
    // sdat as seen on the bus, registered against glitches
    logic sdat_in_q;
    // outgoing word, msb first
    logic [`I2C_CMD_WIDTH-1:0] shift_q;
    // bits sent so far in this transfer
    logic [cnt_w-1:0] bit_cnt_q;
    // some slot of this transfer was not acked
    logic nack_q;
    logic load;
    logic shift;

    assign load  = step && (state_q == st_start1) && cmd_port.cmd_valid;
    assign shift = step && (state_q == st_data1);

    // open drain, only ever pull low
    assign i2c_sclk = sclk_q ? 1'bz : 1'b0;
    assign i2c_sdat = sdat_q ? 1'bz : 1'b0;

    assign cmd_port.cmd_done  = step && (state_q == st_stop3);
    assign cmd_port.cmd_acked = !nack_q;

    // bus sample, used in the ack slot while sclk is high
    always_ff @(posedge osc_50) begin
        sdat_in_q <= i2c_sdat;
    end

    always_ff @(posedge osc_50) begin
        if (load) begin
            shift_q <= cmd_port.cmd;
        end else if (shift) begin
            shift_q <= {shift_q[`I2C_CMD_WIDTH-2:0], 1'b0};
        end
    end

    always_ff @(posedge osc_50) begin
        if (reset_50m) begin
            state_q   <= st_idle;
            sclk_q    <= 1'b1;
            sdat_q    <= 1'b1;
            bit_cnt_q <= '0;
            nack_q    <= 1'b0;
        end else if (step) begin
            case (state_q)
                st_idle: begin
                    // bus released, wait for a command
                    if (cmd_port.cmd_valid) begin
                        state_q <= st_start1;
                    end
                end
                st_start1: begin
                    // both lines high ahead of the start condition
                    sclk_q <= 1'b1;
                    sdat_q <= 1'b1;
                    if (cmd_port.cmd_valid) begin
                        bit_cnt_q <= '0;
                        nack_q    <= 1'b0;
                        state_q   <= st_start2;
                    end else begin
                        state_q <= st_idle;
                    end
                end
                st_start2: begin
                    // start: sdat falls, sclk high
                    sdat_q  <= 1'b0;
                    state_q <= st_start3;
                end
                st_start3: begin
                    sclk_q  <= 1'b0;
                    state_q <= st_data1;
                end
                st_data1: begin
                    // put the next bit out while sclk is low
                    sdat_q    <= shift_q[`I2C_CMD_WIDTH-1];
                    bit_cnt_q <= bit_cnt_q + cnt_w'(1);
                    state_q   <= st_data2;
                end
                st_data2: begin
                    sclk_q  <= 1'b1;
                    state_q <= st_data3;
                end
                st_data3: begin
                    sclk_q <= 1'b0;
                    // byte boundary, hand sdat to the slave
                    if (bit_cnt_q[2:0] == 3'd0) begin
                        sdat_q  <= 1'b1;
                        state_q <= st_ack1;
                    end else begin
                        state_q <= st_data1;
                    end
                end
                st_ack1: begin
                    sclk_q  <= 1'b1;
                    state_q <= st_ack2;
                end
                st_ack2: begin
                    sclk_q <= 1'b0;
                    if (!sdat_in_q) begin
                        if (bit_cnt_q == cnt_w'(`I2C_CMD_WIDTH)) begin
                            sdat_q  <= 1'b0;
                            state_q <= st_stop1;
                        end else begin
                            state_q <= st_data1;
                        end
                    end else begin
                        // no ack, abandon the rest of the word
                        nack_q  <= 1'b1;
                        sdat_q  <= 1'b0;
                        state_q <= st_stop1_err;
                    end
                end
                st_stop1, st_stop1_err: begin
                    // sdat held low, raise sclk first
                    sclk_q  <= 1'b1;
                    state_q <= st_stop2;
                end
                st_stop2: begin
                    // stop: sdat rises, sclk high
                    sdat_q  <= 1'b1;
                    state_q <= st_stop3;
                end
                st_stop3: begin
                    state_q <= st_idle;
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    // sdat moves under a high sclk only for start and stop conditions
    a_sdat_scl_high : assert property (@(posedge osc_50) disable iff (reset_50m)
        (sclk_q && $past(sclk_q) && (sdat_q != $past(sdat_q)))
            |-> ($past(state_q) inside {st_start2, st_stop2}));

    // no phase is shorter or longer than one step
    a_state_on_step : assert property (@(posedge osc_50) disable iff (reset_50m)
        !step |=> $stable(state_q));

endmodule

`default_nettype wire

/* rtl/i2c_config.sv */
// codec config top level: tick generator, command sequencer and bit engine on plain ports
`timescale 1ns/1ns
`default_nettype none

module i2c_config (
    input  logic osc_50,
    input  logic reset_50m,
    input  logic clock_8_1k,
    input  logic clock_valid,
    inout  wire  i2c_sdat,
    output wire  i2c_sclk,
    output logic i2c_audio_done
);

    // one bus phase per tick
    logic step;

    // sequencer to engine handshake
    i2c_cmd_if cmd_bus ();

    i2c_tick_gen i2c_tick_gen_i (
        .osc_50      (osc_50),
        .reset_50m   (reset_50m),
        .clock_8_1k  (clock_8_1k),
        .clock_valid (clock_valid),
        .step        (step)
    );

    i2c_command_seq i2c_command_seq_i (
        .osc_50         (osc_50),
        .reset_50m      (reset_50m),
        .cmd_port       (cmd_bus.seq),
        .i2c_audio_done (i2c_audio_done)
    );

    // drives the open-drain pads
    i2c_bit_engine i2c_bit_engine_i (
        .osc_50    (osc_50),
        .reset_50m (reset_50m),
        .step      (step),
        .cmd_port  (cmd_bus.eng),
        .i2c_sdat  (i2c_sdat),
        .i2c_sclk  (i2c_sclk)
    );

endmodule

`default_nettype wire

/* tests/i2c_bus_checker.sv */
// bus checker: I2C write decoder, expected command model, reset, done and clock_valid checks
`timescale 1ns/1ns
`default_nettype none

module i2c_bus_checker (
    input  logic osc_50,
    input  logic reset_50m,
    input  logic clock_valid,
    input  logic i2c_sclk,
    input  logic i2c_sdat,
    input  logic i2c_audio_done,
    input  logic slave_nack,
    input  logic final_check,
    output int   value_errors,
    output int   bus_errors,
    output int   transfer_count,
    output int   nack_count,
    output int   items_acked
);

    localparam int num_cmds = 7;

    // codec writes in send order: address byte, register, data
    logic [23:0] expected_words [num_cmds];
    // levels seen at the previous negedge
    logic scl_q;
    logic sda_q;
    // clock_valid one and two negedges back
    logic cv_d1;
    logic cv_d2;
    logic in_xfer;
    // all slots done or a nack seen, only the stop is left
    logic stop_armed;
    logic bus_nack;
    logic done_seen;
    logic final_done;
    int   rises;
    int   nbits;
    int   acks;
    int   extra_rises;
    logic [23:0] word_rx;

    initial begin
        expected_words = '{{8'h34, 7'h0f, 9'h000}, {8'h34, 7'h06, 9'h000},
                           {8'h34, 7'h04, 9'h014}, {8'h34, 7'h05, 9'h000},
                           {8'h34, 7'h08, 9'h00c}, {8'h34, 7'h07, 9'h01b},
                           {8'h34, 7'h09, 9'h001}};
        {value_errors, bus_errors, transfer_count, nack_count, items_acked} = '0;
        {scl_q, sda_q, cv_d1, cv_d2} = 4'b1111;
        {in_xfer, stop_armed, bus_nack, done_seen, final_done} = 5'b00000;
    end

    task automatic compare_value(input string name, input logic [23:0] got,
                                 input logic [23:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic report_bus(input string what);
        $display("bus error at %0t ns: %s", $time, what);
        bus_errors++;
    endtask

    // stop seen: score the word against the model item
    task automatic end_transfer();
        transfer_count++;
        if (bus_nack !== slave_nack) report_bus("ack slots on the bus disagree with the slave");
        if (items_acked >= num_cmds) begin
            report_bus("transfer after all commands were acknowledged");
        end else if (bus_nack) begin
            // same item goes out again
            nack_count++;
            if (nbits != 8 * (acks + 1)) begin
                report_bus($sformatf("nacked transfer stopped after %0d bits", nbits));
            end else begin
                compare_value("nacked word prefix", word_rx,
                              expected_words[items_acked] >> (24 - nbits));
            end
        end else if (acks != 3 || nbits != 24) begin
            report_bus($sformatf("transfer ended after %0d bits and %0d acks", nbits, acks));
        end else begin
            compare_value("address byte", word_rx[23:16], 8'h34);
            compare_value("command word", word_rx, expected_words[items_acked]);
            items_acked++;
        end
    endtask

    always @(negedge osc_50) begin
        if (reset_50m) begin
            compare_value("i2c_sclk", i2c_sclk, 1'b1);
            compare_value("i2c_sdat", i2c_sdat, 1'b1);
            compare_value("i2c_audio_done", i2c_audio_done, 1'b0);
        end else begin
            // a step lags clock_valid by one cycle, the bus by one more
            if ((i2c_sclk !== scl_q || i2c_sdat !== sda_q) && !cv_d2)
                report_bus("bus line changed while clock_valid was low");
            if (i2c_sclk && scl_q && sda_q && !i2c_sdat) begin
                // start condition
                if (done_seen) report_bus("start condition after i2c_audio_done");
                if (in_xfer) report_bus("repeated start inside a transfer");
                {in_xfer, stop_armed, bus_nack} = 3'b100;
                {rises, nbits, acks, extra_rises} = '0;
                word_rx = '0;
            end else if (i2c_sclk && scl_q && !sda_q && i2c_sdat) begin
                // stop condition
                if (in_xfer) end_transfer();
                else report_bus("stop condition without a start");
                in_xfer = 1'b0;
            end else if (i2c_sclk && !scl_q) begin
                if (!in_xfer) begin
                    report_bus("sclk pulse outside a transfer");
                end else if (stop_armed) begin
                    // one pulse sets up the stop
                    extra_rises++;
                    if (extra_rises > 1) report_bus("sclk pulse after the last ack slot");
                end else begin
                    rises++;
                    if (rises % 9 == 0) begin
                        // ack slot, slave pulls low
                        bus_nack   = i2c_sdat;
                        acks       = acks + (i2c_sdat ? 0 : 1);
                        stop_armed = i2c_sdat || acks == 3;
                    end else begin
                        word_rx = {word_rx[22:0], i2c_sdat};
                        nbits++;
                    end
                end
            end
            // done only after the seventh ack, then sticky
            if (i2c_audio_done === 1'b1) begin
                if (!done_seen && items_acked != num_cmds)
                    report_bus($sformatf("i2c_audio_done rose with %0d commands acked", items_acked));
                done_seen = 1'b1;
            end else if (done_seen) begin
                compare_value("i2c_audio_done", i2c_audio_done, 1'b1);
            end
        end
        if (final_check && !final_done) begin
            final_done = 1'b1;
            if (items_acked != num_cmds)
                report_bus($sformatf("only %0d of %0d commands acked", items_acked, num_cmds));
            if (!done_seen) report_bus("i2c_audio_done never rose");
        end
        cv_d2 = cv_d1;
        cv_d1 = clock_valid;
        scl_q = i2c_sclk;
        sda_q = i2c_sdat;
    end

endmodule

`default_nettype wire

/* tests/tb_i2c_config.sv */
// testbench top: clocks, reset, clock_valid gaps, slave ack model, DUT, bus checker, timeout
`timescale 1ns/1ns
`default_nettype none

module tb_i2c_config;

    localparam int half_period = 50;
    localparam int drive_delay = 5;
    localparam int reset_cycles = 16;
    // clock_8_1k half period in osc_50 cycles
    localparam int slow_half = 4;
    localparam int max_tries = 3;
    localparam int timeout_cycles = (7 * max_tries * 84 + 100) * 2 * slow_half;
    // quiet time after done, longer than one whole transfer
    localparam int tail_cycles = 200 * 2 * slow_half;

    logic osc_50;
    logic reset_50m;
    logic clock_8_1k;
    logic clock_valid;
    // slave pulls sdat low in an ack slot
    logic slave_pull;
    // slave left an ack slot of this transfer released
    logic slave_nack;
    logic final_check;
    logic timed_out;
    wire  i2c_sdat;
    wire  i2c_sclk;
    wire  i2c_audio_done;
    int   cycle_count = 0;
    int   value_errors;
    int   bus_errors;
    int   transfer_count;
    int   nack_count;
    int   items_acked;

    // open drain, released lines float high
    pullup (i2c_sclk);
    pullup (i2c_sdat);
    assign i2c_sdat = slave_pull ? 1'b0 : 1'bz;

    initial osc_50 = 1'b0;
    always #half_period osc_50 = ~osc_50;

    always @(posedge osc_50) begin
        cycle_count <= cycle_count + 1;
    end

    i2c_config i2c_config_i (
        .osc_50         (osc_50),
        .reset_50m      (reset_50m),
        .clock_8_1k     (clock_8_1k),
        .clock_valid    (clock_valid),
        .i2c_sdat       (i2c_sdat),
        .i2c_sclk       (i2c_sclk),
        .i2c_audio_done (i2c_audio_done)
    );

    i2c_bus_checker i2c_bus_checker_i (
        .osc_50          (osc_50),
        .reset_50m       (reset_50m),
        .clock_valid     (clock_valid),
        .i2c_sclk        (i2c_sclk),
        .i2c_sdat        (i2c_sdat),
        .i2c_audio_done  (i2c_audio_done),
        .slave_nack      (slave_nack),
        .final_check     (final_check),
        .value_errors    (value_errors),
        .bus_errors      (bus_errors),
        .transfer_count  (transfer_count),
        .nack_count      (nack_count),
        .items_acked     (items_acked)
    );

    // every input moves drive_delay after a rising edge, one random stream
    initial begin : stimulus
        int   cycle_idx;
        int   gap_left;
        int   rises;
        int   nack_streak;
        logic scl_seen;
        logic sda_seen;
        void'($urandom(15454));
        reset_50m   = 1'b1;
        clock_8_1k  = 1'b0;
        clock_valid = 1'b1;
        slave_pull  = 1'b0;
        slave_nack  = 1'b0;
        cycle_idx   = 0;
        gap_left    = 0;
        rises       = 0;
        nack_streak = 0;
        scl_seen    = 1'b1;
        sda_seen    = 1'b1;
        forever begin
            @(posedge osc_50);
            #drive_delay;
            cycle_idx++;
            if (cycle_idx == reset_cycles) reset_50m = 1'b0;
            if (cycle_idx % slow_half == 0) clock_8_1k = ~clock_8_1k;
            // rare clock_valid gaps of 1 to 6 cycles
            if (gap_left > 0) begin
                gap_left--;
                if (gap_left == 0) clock_valid = 1'b1;
            end else if (!reset_50m && ($urandom % 64) == 0) begin
                gap_left    = 1 + ($urandom % 6);
                clock_valid = 1'b0;
            end
            // slave: count sclk rises per byte, ack after the eighth
            if (i2c_sclk && scl_seen && sda_seen && !i2c_sdat) begin
                rises      = 0;
                slave_pull = 1'b0;
                slave_nack = 1'b0;
            end else if (i2c_sclk && scl_seen && !sda_seen && i2c_sdat) begin
                // at most two nacked tries in a row, so every word gets through
                nack_streak = slave_nack ? nack_streak + 1 : 0;
            end else if (i2c_sclk && !scl_seen) begin
                rises++;
            end else if (!i2c_sclk && scl_seen) begin
                if (rises == 8) begin
                    if (nack_streak < max_tries - 1 && ($urandom % 8) == 0) begin
                        slave_nack = 1'b1;
                    end else begin
                        slave_pull = 1'b1;
                    end
                end else if (rises == 9) begin
                    slave_pull = 1'b0;
                    rises      = 0;
                end
            end
            scl_seen = i2c_sclk;
            sda_seen = i2c_sdat;
        end
    end

    initial begin : run_control
        final_check = 1'b0;
        timed_out   = 1'b0;
        @(negedge osc_50);
        while (i2c_audio_done !== 1'b1 && !timed_out) begin
            @(negedge osc_50);
            if (cycle_count >= timeout_cycles) timed_out = 1'b1;
        end
        if (timed_out) begin
            $display("timeout: i2c_audio_done still low after %0d cycles", cycle_count);
        end else begin
            repeat (tail_cycles) @(negedge osc_50);
        end
        final_check = 1'b1;
        @(negedge osc_50);
        @(posedge osc_50);
        $display("summary: %0d value errors, %0d bus errors, %0d timeouts, ",
                 value_errors, bus_errors, timed_out,
                 "%0d transfers, %0d nacks, %0d of 7 acked",
                 transfer_count, nack_count, items_acked);
        if (timed_out || value_errors != 0 || bus_errors != 0) begin
            $display("TESTBENCH FAILED");
        end else begin
            $display("TESTBENCH PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
rtl/i2c_config_pkg.sv
rtl/i2c_cmd_if.sv
rtl/i2c_tick_gen.sv
rtl/i2c_command_seq.sv
rtl/i2c_bit_engine.sv
rtl/i2c_config.sv
tests/i2c_bus_checker.sv
tests/tb_i2c_config.sv

/* Bender.yml */
package:
  name: i2c_config

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/i2c_config_pkg.sv
      - rtl/i2c_cmd_if.sv
      - rtl/i2c_tick_gen.sv
      - rtl/i2c_command_seq.sv
      - rtl/i2c_bit_engine.sv
      - rtl/i2c_config.sv
  - target: test
    files:
      - tests/i2c_bus_checker.sv
      - tests/tb_i2c_config.sv
